// File: hdl/lc3b_params.svh
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// width of a data word and of an address
`define LC3B_WORD_WIDTH 16

// number of general purpose registers, R0 to R7
`define LC3B_NUM_REGS 8

// the first instruction is fetched from this address
`define LC3B_RESET_PC 16'h0000

`endif

// File: hdl/lc3b_types.sv
`include "lc3b_params.svh"

package lc3b_types;

    // one machine word, used for data, addresses and instructions alike
    typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;

    // opcode field IR[15:12], only the implemented subset is named
    // other encodings decode to a no-op
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // operations of the ALU
    // alu_pass hands operand b straight through
    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

endpackage : lc3b_types

// File: hdl/cpu_control_types.sv
package cpu_control_types;

    // states of the multicycle sequencer
    typedef enum logic [3:0] {
        fetch1,
        fetch2,
        fetch3,
        decode,
        s_alu,
        s_br,
        br_taken,
        calc_addr,
        ldr1,
        ldr2,
        str1,
        str2
    } control_state;

    // next PC is either the next word or the branch target
    typedef enum logic {
        pc_plus2,
        pc_branch
    } pcmux_sel_t;

    // second ALU operand
    typedef enum logic [1:0] {
        sr2_reg,
        imm5,
        offset6
    } alumux_sel_t;

    // value written back to the register file
    typedef enum logic {
        from_alu,
        from_mdr
    } regfilemux_sel_t;

    typedef enum logic {
        mar_from_alu,
        mar_from_pc
    } marmux_sel_t;

    // MDR takes read data from the bus or the store source register
    typedef enum logic {
        mdr_from_bus,
        mdr_from_sr
    } mdrmux_sel_t;

endpackage : cpu_control_types

// File: hdl/alu.sv
`timescale 1ns/100ps

module alu
    import lc3b_types::*;
(
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    // purely combinational, the result settles within the state that uses it
    always_comb begin
        f = b;
        case (aluop)
            alu_add: begin
                f = a + b;
            end
            alu_and: begin
                f = a & b;
            end
            alu_not: begin
                f = ~a;
            end
            alu_pass: begin
                f = b;
            end
        endcase
    end

endmodule : alu

// File: hdl/regfile.sv
`timescale 1ns/100ps
`include "lc3b_params.svh"

module regfile
    import lc3b_types::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    input  logic [2:0] src_a,
    input  logic [2:0] src_b,
    input  logic [2:0] dest,
    input  lc3b_word   in_data,
    output lc3b_word   reg_a,
    output lc3b_word   reg_b
);

    lc3b_word data [`LC3B_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in_data;
        end
    end

    // asynchronous reads, a write shows up on the port in the next cycle
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

endmodule : regfile

// File: hdl/cpu_datapath.sv
`timescale 1ns/100ps
`include "lc3b_params.svh"

module cpu_datapath
    import lc3b_types::*;
    import cpu_control_types::*;
(
    input  logic            clk,
    input  logic            reset,

    // read data from the bus
    input  lc3b_word        mem_dat_s,

    // from cpu_control
    input  logic            load_pc,
    input  logic            load_ir,
    input  logic            load_regfile,
    input  logic            load_mar,
    input  logic            load_mdr,
    input  logic            load_cc,
    input  pcmux_sel_t      pcmux_sel,
    input  alumux_sel_t     alumux_sel,
    input  regfilemux_sel_t regfilemux_sel,
    input  marmux_sel_t     marmux_sel,
    input  mdrmux_sel_t     mdrmux_sel,
    input  lc3b_aluop       aluop,

    // to the bus
    output lc3b_word        mem_adr,
    output lc3b_word        mem_dat_m,

    // to cpu_control
    output lc3b_opcode      opcode,
    output logic            inst5,
    output logic            branch_enable
);

    lc3b_word   pc;
    lc3b_word   ir;
    lc3b_word   mar;
    lc3b_word   mdr;
    logic [2:0] nzp;

    lc3b_word   pc_next;
    lc3b_word   imm5_sext;
    lc3b_word   offset6_sext;
    lc3b_word   offset9_sext;
    lc3b_word   reg_a;
    lc3b_word   reg_b;
    lc3b_word   alu_b;
    lc3b_word   alu_out;
    lc3b_word   regfile_in;
    logic [2:0] src_b;
    logic [2:0] nzp_next;

    // ************************************************************************
    // instruction fields
    // ************************************************************************

    assign opcode = lc3b_opcode'(ir[15:12]);
    assign inst5  = ir[5];

    // STR reads its source from the DR field, every other form from SR2
    assign src_b = (opcode == op_str) ? ir[11:9] : ir[2:0];

    assign imm5_sext    = {{(`LC3B_WORD_WIDTH-5){ir[4]}}, ir[4:0]};
    // word offsets are scaled to byte addresses
    assign offset6_sext = {{(`LC3B_WORD_WIDTH-7){ir[5]}}, ir[5:0], 1'b0};
    assign offset9_sext = {{(`LC3B_WORD_WIDTH-10){ir[8]}}, ir[8:0], 1'b0};

    // ************************************************************************
    // register file, ALU and write-back
    // ************************************************************************

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .load    (load_regfile),
        .src_a   (ir[8:6]),
        .src_b   (src_b),
        .dest    (ir[11:9]),
        .in_data (regfile_in),
        .reg_a   (reg_a),
        .reg_b   (reg_b)
    );

    always_comb begin
        case (alumux_sel)
            imm5:    alu_b = imm5_sext;
            offset6: alu_b = offset6_sext;
            default: alu_b = reg_b;
        endcase
    end

    alu u_alu (
        .aluop (aluop),
        .a     (reg_a),
        .b     (alu_b),
        .f     (alu_out)
    );

    assign regfile_in = (regfilemux_sel == from_mdr) ? mdr : alu_out;

    // condition codes follow the value being written back
    assign nzp_next[2] = regfile_in[`LC3B_WORD_WIDTH-1];
    assign nzp_next[1] = (regfile_in == '0);
    assign nzp_next[0] = !nzp_next[2] && !nzp_next[1];

    assign branch_enable = |(ir[11:9] & nzp);

    // PC already points past the branch when the target is formed
    assign pc_next = (pcmux_sel == pc_branch) ? (pc + offset9_sext) : (pc + lc3b_word'(2));

    // ************************************************************************
    // architectural registers
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            pc  <= `LC3B_RESET_PC;
            nzp <= 3'b010;
        end else begin
            if (load_pc) begin
                pc <= pc_next;
            end
            if (load_cc) begin
                nzp <= nzp_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir) begin
            ir <= mdr;
        end
        if (load_mar) begin
            mar <= (marmux_sel == mar_from_pc) ? pc : alu_out;
        end
        if (load_mdr) begin
            mdr <= (mdrmux_sel == mdr_from_sr) ? reg_b : mem_dat_s;
        end
    end

    assign mem_adr   = mar;
    assign mem_dat_m = mdr;

endmodule : cpu_datapath

// File: hdl/cpu_control.sv
`timescale 1ns/100ps

module cpu_control
    import lc3b_types::*;
    import cpu_control_types::*;
(
    input  logic            clk,
    input  logic            reset,

    // from cpu_datapath
    input  lc3b_opcode      opcode,
    input  logic            inst5,
    input  logic            branch_enable,

    // from the bus slave
    input  logic            mem_ack,

    // to cpu_datapath
    output logic            load_pc,
    output logic            load_ir,
    output logic            load_regfile,
    output logic            load_mar,
    output logic            load_mdr,
    output logic            load_cc,
    output pcmux_sel_t      pcmux_sel,
    output alumux_sel_t     alumux_sel,
    output regfilemux_sel_t regfilemux_sel,
    output marmux_sel_t     marmux_sel,
    output mdrmux_sel_t     mdrmux_sel,
    output lc3b_aluop       aluop,

    // to the bus, mem_read_write high means write
    output logic            mem_request,
    output logic            mem_read_write
);

    control_state state;
    control_state next_state;

    // ************************************************************************
    // state outputs
    // ************************************************************************

    always_comb begin
        load_pc        = 1'b0;
        load_ir        = 1'b0;
        load_regfile   = 1'b0;
        load_mar       = 1'b0;
        load_mdr       = 1'b0;
        load_cc        = 1'b0;
        pcmux_sel      = pc_plus2;
        alumux_sel     = sr2_reg;
        regfilemux_sel = from_alu;
        marmux_sel     = mar_from_pc;
        mdrmux_sel     = mdr_from_bus;
        aluop          = alu_pass;
        mem_request    = 1'b0;
        mem_read_write = 1'b0;

        case (state)
            fetch1: begin
                // MAR takes the current PC while PC steps to the next word
                load_mar = 1'b1;
                load_pc  = 1'b1;
            end
            fetch2, ldr1: begin
                // MDR samples every cycle, the ACK cycle leaves the valid word
                mem_request = 1'b1;
                load_mdr    = 1'b1;
            end
            fetch3: begin
                load_ir = 1'b1;
            end
            s_alu: begin
                case (opcode)
                    op_and:  aluop = alu_and;
                    op_not:  aluop = alu_not;
                    default: aluop = alu_add;
                endcase
                alumux_sel   = inst5 ? imm5 : sr2_reg;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            br_taken: begin
                pcmux_sel = pc_branch;
                load_pc   = 1'b1;
            end
            calc_addr: begin
                aluop      = alu_add;
                alumux_sel = offset6;
                marmux_sel = mar_from_alu;
                load_mar   = 1'b1;
            end
            ldr2: begin
                regfilemux_sel = from_mdr;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            str1: begin
                mdrmux_sel = mdr_from_sr;
                load_mdr   = 1'b1;
            end
            str2: begin
                mem_request    = 1'b1;
                mem_read_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ************************************************************************
    // next state
    // ************************************************************************

    always_comb begin
        next_state = state;
        case (state)
            fetch1:    next_state = fetch2;
            fetch2:    next_state = mem_ack ? fetch3 : fetch2;
            fetch3:    next_state = decode;
            decode: begin
                case (opcode)
                    op_add, op_and, op_not: next_state = s_alu;
                    op_br:                  next_state = s_br;
                    op_ldr, op_str:         next_state = calc_addr;
                    default:                next_state = fetch1;
                endcase
            end
            s_br:      next_state = branch_enable ? br_taken : fetch1;
            calc_addr: next_state = (opcode == op_str) ? str1 : ldr1;
            ldr1:      next_state = mem_ack ? ldr2 : ldr1;
            str1:      next_state = str2;
            str2:      next_state = mem_ack ? fetch1 : str2;
            default:   next_state = fetch1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch1;
        end else begin
            state <= next_state;
        end
    end

endmodule : cpu_control

// File: hdl/cpu.sv
`timescale 1ns/100ps

module cpu
    import lc3b_types::*;
    import cpu_control_types::*;
(
    input  logic     clk,
    input  logic     reset,

    // Wishbone master
    output lc3b_word mem_adr,
    output lc3b_word mem_dat_m,
    input  lc3b_word mem_dat_s,
    output logic     mem_cyc,
    output logic     mem_stb,
    output logic     mem_we,
    input  logic     mem_ack
);

    // cycle and strobe always move together on this bus
    logic mem_request;
    assign mem_cyc = mem_request;
    assign mem_stb = mem_request;

    // datapath to control
    lc3b_opcode      opcode;
    logic            inst5;
    logic            branch_enable;

    // control to datapath
    logic            load_pc;
    logic            load_ir;
    logic            load_regfile;
    logic            load_mar;
    logic            load_mdr;
    logic            load_cc;
    pcmux_sel_t      pcmux_sel;
    alumux_sel_t     alumux_sel;
    regfilemux_sel_t regfilemux_sel;
    marmux_sel_t     marmux_sel;
    mdrmux_sel_t     mdrmux_sel;
    lc3b_aluop       aluop;

    cpu_control u_cpu_control (
        .clk            (clk),
        .reset          (reset),
        .opcode         (opcode),
        .inst5          (inst5),
        .branch_enable  (branch_enable),
        .mem_ack        (mem_ack),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .aluop          (aluop),
        .mem_request    (mem_request),
        .mem_read_write (mem_we)
    );

    cpu_datapath u_cpu_datapath (
        .clk            (clk),
        .reset          (reset),
        .mem_dat_s      (mem_dat_s),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .aluop          (aluop),
        .mem_adr        (mem_adr),
        .mem_dat_m      (mem_dat_m),
        .opcode         (opcode),
        .inst5          (inst5),
        .branch_enable  (branch_enable)
    );

endmodule : cpu

// File: verification/cpu_properties.sv
`timescale 1ns/100ps

module cpu_properties
    import lc3b_types::*;
    import cpu_control_types::*;
(
    input logic         clk,
    input logic         reset,
    input lc3b_word     mem_adr,
    input lc3b_word     mem_dat_m,
    input logic         mem_cyc,
    input logic         mem_stb,
    input logic         mem_we,
    input logic         mem_ack,
    input control_state state
);

    cyc_stb_equal: assert property (@(posedge clk) disable iff (reset)
        mem_stb == mem_cyc)
        else $error("mem_stb differs from mem_cyc");

    // write data is held only on a write because a read refreshes the MDR while it waits
    request_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_cyc && !mem_ack) |=>
            ($stable(mem_adr) && $stable(mem_we) && (!mem_we || $stable(mem_dat_m))))
        else $error("bus request changed before mem_ack");

    cyc_drop_after_ack: assert property (@(posedge clk) disable iff (reset)
        mem_ack |=> !mem_cyc)
        else $error("mem_cyc still high in the cycle after mem_ack");

    // the sequencer restarts in fetch1 with the bus idle
    idle_after_reset: assert property (@(posedge clk)
        reset |=> (!mem_cyc && state == fetch1))
        else $error("bus not idle in fetch1 in the cycle after reset");

endmodule : cpu_properties

bind cpu cpu_properties u_cpu_properties (
    .clk       (clk),
    .reset     (reset),
    .mem_adr   (mem_adr),
    .mem_dat_m (mem_dat_m),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_ack   (mem_ack),
    .state     (u_cpu_control.state)
);

// File: verification/cpu_tb.sv
`timescale 1ns/100ps
`include "lc3b_params.svh"

module cpu_tb
    import lc3b_types::*;
();

    localparam int MEM_WORDS   = 256;
    localparam int FIRST_LIMIT = 50;
    localparam int STORE_LIMIT = 300;
    localparam int HALT_LIMIT  = 300;

    logic        clk;
    logic        reset;
    lc3b_word    mem_adr;
    lc3b_word    mem_dat_m;
    lc3b_word    mem_dat_s;
    logic        mem_cyc;
    logic        mem_stb;
    logic        mem_we;
    logic        mem_ack;

    lc3b_word    mem [MEM_WORDS];
    lc3b_word    exp_adr [$];
    lc3b_word    exp_dat [$];
    lc3b_word    halt_adr;
    logic        ref_halted;
    int          num_expected;
    int          stores_seen;
    int          prog_idx;
    int unsigned lcg_state;
    int          wait_left;
    logic        busy;

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    cpu uut (
        .clk       (clk),
        .reset     (reset),
        .mem_adr   (mem_adr),
        .mem_dat_m (mem_dat_m),
        .mem_dat_s (mem_dat_s),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_ack   (mem_ack)
    );

    // ************************************************************************
    // helpers
    // ************************************************************************

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic report_mismatch(string what, lc3b_word expected, lc3b_word actual);
        $display("[ERROR] %0t: %s expected %h, got %h", $time, what, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(string why);
        $display("%0t: %s", $time, why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // instruction encoders that cut register numbers and offsets to their fields
    function automatic lc3b_word alu_reg(lc3b_opcode op, int dr, int sr1, int sr2);
        return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
    endfunction

    function automatic lc3b_word alu_imm(lc3b_opcode op, int dr, int sr1, int imm);
        return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic lc3b_word not_word(int dr, int sr);
        return {op_not, dr[2:0], sr[2:0], 6'b111111};
    endfunction

    function automatic lc3b_word branch(int nzp, int off9);
        return {op_br, nzp[2:0], off9[8:0]};
    endfunction

    function automatic lc3b_word mem_instr(lc3b_opcode op, int r, int base, int off6);
        return {op, r[2:0], base[2:0], off6[5:0]};
    endfunction

    task automatic place(lc3b_word instr);
        mem[prog_idx] = instr;
        prog_idx++;
    endtask

    // ************************************************************************
    // program image
    // ************************************************************************

    task automatic load_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
        end
        prog_idx = 0;
        // R7 becomes the data pointer 0x0100
        place(alu_imm(op_add, 7, 0, 8));
        repeat (5) place(alu_reg(op_add, 7, 7, 7));
        place(alu_imm(op_add, 1, 0, -3));
        place(alu_imm(op_add, 2, 0, 13));
        place(alu_reg(op_add, 3, 1, 2));
        place(mem_instr(op_str, 3, 7, 8));
        place(alu_imm(op_and, 4, 3, 6));
        place(mem_instr(op_str, 4, 7, 9));
        place(alu_reg(op_and, 4, 1, 3));
        place(mem_instr(op_str, 4, 7, 10));
        place(not_word(5, 2));
        place(mem_instr(op_str, 5, 7, 11));
        // copy two words, then one through a negative offset
        place(mem_instr(op_ldr, 1, 7, 0));
        place(mem_instr(op_ldr, 2, 7, 1));
        place(mem_instr(op_str, 1, 7, 12));
        place(mem_instr(op_str, 2, 7, 13));
        place(alu_imm(op_add, 5, 7, 8));
        place(mem_instr(op_ldr, 3, 5, -2));
        place(mem_instr(op_str, 3, 5, -1));
        // each condition once taken and once not taken
        place(branch(3'b100, 1));
        place(mem_instr(op_str, 3, 7, 14));
        place(branch(3'b001, 1));
        place(mem_instr(op_str, 3, 7, 15));
        place(alu_imm(op_and, 6, 6, 0));
        place(branch(3'b101, 1));
        place(mem_instr(op_str, 1, 7, 16));
        place(branch(3'b010, 1));
        place(mem_instr(op_str, 2, 7, 17));
        place(alu_imm(op_add, 6, 6, -1));
        place(branch(3'b011, 1));
        place(mem_instr(op_str, 6, 7, 18));
        place(branch(3'b100, 1));
        place(mem_instr(op_str, 6, 7, 19));
        place(mem_instr(op_ldr, 4, 7, 1));
        place(branch(3'b010, 1));
        place(mem_instr(op_str, 4, 7, 20));
        place(mem_instr(op_str, 4, 7, 21));
        // short counted loop with a backward branch
        place(alu_imm(op_add, 6, 0, 3));
        place(mem_instr(op_str, 6, 5, 20));
        place(alu_imm(op_add, 5, 5, 2));
        place(alu_imm(op_add, 6, 6, -1));
        place(branch(3'b001, -4));
        // an unimplemented opcode falls through as a no-op
        place(16'hD000);
        place(mem_instr(op_str, 6, 7, 31));
        place(branch(3'b111, -1));
        mem[128] = 16'h8001;
        mem[129] = 16'h0000;
        mem[130] = 16'h1234;
        mem[131] = 16'h5A5A;
    endtask

    // ************************************************************************
    // reference ISA model
    // ************************************************************************

    function automatic void run_reference();
        lc3b_word   rmem [MEM_WORDS];
        lc3b_word   regs [8];
        lc3b_word   pc;
        lc3b_word   ir;
        lc3b_word   opnd;
        lc3b_word   addr;
        lc3b_word   result;
        logic [2:0] cc;
        logic       writes;
        int         steps;

        rmem = mem;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        pc = `LC3B_RESET_PC;
        cc = 3'b010;
        steps = 0;
        ref_halted = 1'b0;
        while (!ref_halted && steps < 1000) begin
            ir = rmem[pc[8:1]];
            if (ir == 16'h0FFF) begin
                ref_halted = 1'b1;
                halt_adr = pc;
            end else begin
                pc = pc + 16'd2;
                writes = 1'b0;
                result = '0;
                opnd = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
                addr = regs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
                case (lc3b_opcode'(ir[15:12]))
                    op_add: begin
                        result = regs[ir[8:6]] + opnd;
                        writes = 1'b1;
                    end
                    op_and: begin
                        result = regs[ir[8:6]] & opnd;
                        writes = 1'b1;
                    end
                    op_not: begin
                        result = ~regs[ir[8:6]];
                        writes = 1'b1;
                    end
                    op_ldr: begin
                        result = rmem[addr[8:1]];
                        writes = 1'b1;
                    end
                    op_str: begin
                        rmem[addr[8:1]] = regs[ir[11:9]];
                        exp_adr.push_back(addr);
                        exp_dat.push_back(regs[ir[11:9]]);
                    end
                    op_br: begin
                        if (|(ir[11:9] & cc)) begin
                            pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
                        end
                    end
                    default: begin
                    end
                endcase
                if (writes) begin
                    regs[ir[11:9]] = result;
                    cc = {result[15], result == '0, !result[15] && (result != '0)};
                end
            end
            steps++;
        end
    endfunction

    // ************************************************************************
    // memory model and store checker
    // ************************************************************************

    always @(posedge clk) begin
        if (reset) begin
            mem_ack <= 1'b0;
            busy = 1'b0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_cyc && mem_stb && !mem_ack) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_left = next_random() % 4;
                end
                if (wait_left == 0) begin
                    busy = 1'b0;
                    mem_ack <= 1'b1;
                    if (mem_we) begin
                        mem[mem_adr[8:1]] = mem_dat_m;
                    end else begin
                        mem_dat_s <= mem[mem_adr[8:1]];
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && mem_cyc && mem_we && mem_ack) begin
            assert (stores_seen < num_expected)
                else abort_run("the DUT wrote to memory after the last expected store");
            assert (mem_adr == exp_adr[stores_seen])
                else report_mismatch("store address", exp_adr[stores_seen], mem_adr);
            assert (mem_dat_m == exp_dat[stores_seen])
                else report_mismatch("store data", exp_dat[stores_seen], mem_dat_m);
            stores_seen++;
        end
    end

    // ************************************************************************
    // main sequence
    // ************************************************************************

    initial begin
        int cycles;

        reset = 1'b1;
        mem_ack = 1'b0;
        mem_dat_s = '0;
        lcg_state = 46298;
        busy = 1'b0;
        wait_left = 0;
        stores_seen = 0;
        halt_adr = '0;
        load_image();
        run_reference();
        num_expected = exp_adr.size();
        assert (ref_halted)
            else abort_run("the reference model never reached the halt loop");

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (!mem_cyc && cycles < FIRST_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (mem_cyc) else abort_run("timeout waiting for the first bus request");
        assert (!mem_we)
            else report_mismatch("first request mem_we", 16'h0000, {15'h0000, mem_we});
        assert (mem_adr == `LC3B_RESET_PC)
            else report_mismatch("first fetch address", `LC3B_RESET_PC, mem_adr);

        for (int n = 0; n < num_expected; n++) begin
            cycles = 0;
            while (stores_seen <= n && cycles < STORE_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            assert (stores_seen > n)
                else abort_run($sformatf("timeout waiting for store number %0d", n));
        end

        cycles = 0;
        while (!(mem_cyc && !mem_we && mem_ack && mem_adr == halt_adr)
               && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (mem_cyc && !mem_we && mem_ack && mem_adr == halt_adr)
            else abort_run("timeout waiting for the fetch of the halt loop");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : cpu_tb

// File: verilog.f
+incdir+hdl
hdl/lc3b_types.sv
hdl/cpu_control_types.sv
hdl/alu.sv
hdl/regfile.sv
hdl/cpu_datapath.sv
hdl/cpu_control.sv
hdl/cpu.sv
verification/cpu_properties.sv
verification/cpu_tb.sv
